// ==== build.f ====
+incdir+hw
hw/io_pkg.sv
hw/io_pin_sync.sv
hw/io_decode.sv
hw/io_execute.sv
hw/io_result.sv
hw/io_core.sv
hw/io_pad_top.sv
tb/tb_clock_gen.sv
tb/io_asserts.sv
tb/io_tb.sv

// ==== tb/io_tb.sv ====
// Testbench io_tb with stimulus, LFSR, pad drivers, reference model and response checker
`timescale 1ns/1ps
`default_nettype none

`include "io_cfg.svh"

module io_tb;
	import io_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;

	logic                  clock;
	logic                  rst_n;
	logic                  cmd_valid;
	logic                  cmd_write;
	logic [`IO_ADDR_W-1:0] cmd_addr;
	io_data_t              cmd_wdata;
	logic                  rsp_valid;
	io_data_t              rsp_rdata;
	logic                  rsp_err;
	logic [7:0]            seg_char;
	logic [7:0]            seg_seg;
	wire                   ps2_clk;
	wire                   ps2_data;
	wire  [`IO_SDC_W-1:0]  sdc_dat;
	logic [`IO_PS2_W-1:0]  ext_ps2_low;	// External device pulling low
	logic [`IO_SDC_W-1:0]  ext_sdc_low;
	logic [31:0]           lfsr;
	int                    cycle_cnt = 0;
	io_data_t              exp_data_q [$];
	logic                  exp_err_q [$];
	int                    cmd_cycle_q [$];
	logic [7:0]            m_seg_char;	// Shadow register file
	logic [7:0]            m_seg_seg;
	logic [`IO_PS2_W-1:0]  m_ps2_out;
	logic [`IO_PS2_W-1:0]  m_ps2_drv;
	logic [`IO_SDC_W-1:0]  m_sdc_out;
	logic [`IO_SDC_W-1:0]  m_sdc_drv;

	tb_clock_gen u_clock_gen (.clock_o(clock), .rst_n_o(rst_n));

	pullup (ps2_clk);
	pullup (ps2_data);
	assign ps2_clk  = ext_ps2_low[0] ? 1'b0 : 1'bz;
	assign ps2_data = ext_ps2_low[1] ? 1'b0 : 1'bz;
	for (genvar i = 0; i < `IO_SDC_W; i++) begin : g_sdc_ext
		pullup (sdc_dat[i]);
		assign sdc_dat[i] = ext_sdc_low[i] ? 1'b0 : 1'bz;
	end

	io_pad_top u_dut (
		.clock_i(clock), .rst_n_i(rst_n),
		.cmd_valid_i(cmd_valid), .cmd_write_i(cmd_write),
		.cmd_addr_i(cmd_addr), .cmd_wdata_i(cmd_wdata),
		.rsp_valid_o(rsp_valid), .rsp_rdata_o(rsp_rdata), .rsp_err_o(rsp_err),
		.seg_char_o(seg_char), .seg_seg_o(seg_seg),
		.ps2_clk(ps2_clk), .ps2_data(ps2_data), .sdc_dat(sdc_dat)
	);

	bind io_core io_asserts u_asserts (
		.clock_i(clock_i), .rst_n_i(rst_n_i), .cmd_valid_i(cmd_valid_i),
		.rsp_valid_i(rsp_valid_o), .rsp_rdata_i(rsp_rdata_o), .rsp_err_i(rsp_err_o)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	// Galois form, taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// Driven pad shows OUT, released pad reads 1 unless pulled low
	function automatic logic [3:0] pad_levels(input logic [3:0] drv, out, ext);
		return (drv & out) | (~drv & ~ext);
	endfunction

	function automatic void expect_rsp(input logic wr, input logic [7:0] addr,
		input io_data_t wdata, output logic err, output io_data_t rdata);
		logic [3:0] ps2_lvl;
		logic [3:0] sdc_lvl;
		ps2_lvl = pad_levels({2'b00, m_ps2_drv}, {2'b00, m_ps2_out},
			{2'b00, ext_ps2_low});
		sdc_lvl = pad_levels(m_sdc_drv, m_sdc_out, ext_sdc_low);
		err     = (addr >= 8'd8) ||
			(wr && (addr[2:0] == REG_PS2_IN || addr[2:0] == REG_SDC_IN));
		rdata   = '0;
		if (!err && wr) begin
			case (addr[2:0])
				REG_SEG_CHAR: m_seg_char = wdata[7:0];
				REG_SEG_SEG:  m_seg_seg  = wdata[7:0];
				REG_PS2_OUT:  m_ps2_out  = wdata[1:0];
				REG_PS2_DRV:  m_ps2_drv  = wdata[1:0];
				REG_SDC_OUT:  m_sdc_out  = wdata[3:0];
				REG_SDC_DRV:  m_sdc_drv  = wdata[3:0];
				default: ;
			endcase
		end else if (!err) begin
			case (addr[2:0])
				REG_SEG_CHAR: rdata[7:0] = m_seg_char;
				REG_SEG_SEG:  rdata[7:0] = m_seg_seg;
				REG_PS2_OUT:  rdata[1:0] = m_ps2_out;
				REG_PS2_DRV:  rdata[1:0] = m_ps2_drv;
				REG_PS2_IN:   rdata[1:0] = ps2_lvl[1:0];
				REG_SDC_OUT:  rdata[3:0] = m_sdc_out;
				REG_SDC_DRV:  rdata[3:0] = m_sdc_drv;
				default:      rdata[3:0] = sdc_lvl;
			endcase
		end
	endfunction

	task automatic send_cmd(input logic wr, input logic [`IO_ADDR_W-1:0] addr,
		input io_data_t wdata);
		logic     err;
		io_data_t rdata;
		@(posedge clock);
		cmd_valid <= 1'b1;
		cmd_write <= wr;
		cmd_addr  <= addr;
		cmd_wdata <= wdata;
		expect_rsp(wr, addr, wdata, err, rdata);
		exp_data_q.push_back(rdata);
		exp_err_q.push_back(err);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			cmd_valid <= 1'b0;
		end
	endtask

	task automatic wait_drain();
		int cnt;
		cnt = 0;
		while (exp_data_q.size() != 0) begin
			if (cnt >= TIMEOUT_CYCLES)
				abort_run("Timeout waiting for outstanding responses");
			idle_cycles(1);
			cnt++;
		end
	endtask

	task automatic read_all();
		for (int a = 0; a < 8; a++)
			send_cmd(1'b0, a[`IO_ADDR_W-1:0], '0);
		wait_drain();
	endtask

	task automatic check_outputs();
		logic [3:0] ps2_lvl;
		logic [3:0] sdc_lvl;
		ps2_lvl = pad_levels({2'b00, m_ps2_drv}, {2'b00, m_ps2_out},
			{2'b00, ext_ps2_low});
		sdc_lvl = pad_levels(m_sdc_drv, m_sdc_out, ext_sdc_low);
		assert (seg_char === m_seg_char) else abort_run($sformatf(
			"CHECK FAILED seg_char_o exp %h got %h", m_seg_char, seg_char));
		assert (seg_seg === m_seg_seg) else abort_run($sformatf(
			"CHECK FAILED seg_seg_o exp %h got %h", m_seg_seg, seg_seg));
		assert ({ps2_data, ps2_clk} === ps2_lvl[1:0]) else abort_run($sformatf(
			"CHECK FAILED {ps2_data, ps2_clk} exp %h got %h", ps2_lvl[1:0],
			{ps2_data, ps2_clk}));
		assert (sdc_dat === sdc_lvl) else abort_run($sformatf(
			"CHECK FAILED sdc_dat exp %h got %h", sdc_lvl, sdc_dat));
	endtask

	// Checks each response against the queue, in order and three cycles late
	always @(posedge clock) begin : compare_rsp
		int issued;
		cycle_cnt = cycle_cnt + 1;
		if (cmd_valid === 1'b1)
			cmd_cycle_q.push_back(cycle_cnt);
		if (rsp_valid === 1'b1) begin
			assert (exp_data_q.size() != 0 && cmd_cycle_q.size() != 0)
				else abort_run("Response strobe seen with no command outstanding");
			issued = cmd_cycle_q.pop_front();
			assert (cycle_cnt - issued == 3) else abort_run($sformatf(
				"CHECK FAILED response latency exp %h got %h", 3, cycle_cnt - issued));
			assert (rsp_err === exp_err_q[0]) else abort_run($sformatf(
				"CHECK FAILED rsp_err_o exp %h got %h", exp_err_q[0], rsp_err));
			assert (rsp_rdata === exp_data_q[0]) else abort_run($sformatf(
				"CHECK FAILED rsp_rdata_o exp %h got %h", exp_data_q[0], rsp_rdata));
			void'(exp_err_q.pop_front());
			void'(exp_data_q.pop_front());
		end
	end

	initial begin : stimulus
		logic [31:0] v_a;
		logic [31:0] v_b;
		logic [31:0] v_c;
		logic [31:0] v_d;
		int          cnt;
		cmd_valid   = 1'b0;
		cmd_write   = 1'b0;
		cmd_addr    = '0;
		cmd_wdata   = '0;
		ext_ps2_low = '0;
		ext_sdc_low = '0;
		lfsr        = 32'h4365c5c9;
		{m_seg_char, m_seg_seg, m_ps2_out, m_ps2_drv, m_sdc_out, m_sdc_drv} = '0;
		cnt = 0;
		while (rst_n !== 1'b1) begin
			if (cnt >= TIMEOUT_CYCLES)
				abort_run("Timeout waiting for reset release");
			@(posedge clock);
			cnt++;
		end
		idle_cycles(8);	// Pull-up levels reach the synchronizers
		check_outputs();
		read_all();
		for (int r = 0; r < 4; r++) begin	// Segment registers
			rand_bits(32, v_a);
			rand_bits(32, v_b);
			send_cmd(1'b1, REG_SEG_CHAR, v_a);
			send_cmd(1'b1, REG_SEG_SEG, v_b);
			send_cmd(1'b0, REG_SEG_CHAR, '0);
			send_cmd(1'b0, REG_SEG_SEG, '0);
			wait_drain();
			check_outputs();
		end
		for (int r = 0; r < 6; r++) begin	// Pads with external pull-downs
			rand_bits(32, v_a);
			rand_bits(32, v_b);
			rand_bits(32, v_c);
			rand_bits(32, v_d);
			send_cmd(1'b1, REG_PS2_OUT, v_a);
			send_cmd(1'b1, REG_PS2_DRV, v_b);
			send_cmd(1'b1, REG_SDC_OUT, v_c);
			send_cmd(1'b1, REG_SDC_DRV, v_d);
			wait_drain();
			rand_bits(6, v_a);
			@(posedge clock);
			ext_ps2_low <= v_a[1:0] & ~m_ps2_drv;	// Never fights a driven pad
			ext_sdc_low <= v_a[5:2] & ~m_sdc_drv;
			idle_cycles(8);
			check_outputs();
			read_all();
			@(posedge clock);
			ext_ps2_low <= '0;
			ext_sdc_low <= '0;
		end
		for (int r = 0; r < 12; r++) begin	// Illegal accesses
			rand_bits(8, v_a);
			rand_bits(1, v_b);
			rand_bits(32, v_c);
			v_a[7:0] = (v_a[7:3] == 5'd0) ? v_a[7:0] + 8'd8 : v_a[7:0];
			send_cmd(v_b[0], v_a[7:0], v_c);
			send_cmd(1'b1, r[0] ? REG_PS2_IN : REG_SDC_IN, v_c);
		end
		wait_drain();
		idle_cycles(8);
		read_all();
		check_outputs();
		for (int n = 0; n < 500; n++) begin	// Back-to-back writable registers
			rand_bits(8, v_a);
			rand_bits(1, v_b);
			rand_bits(32, v_c);
			v_a = v_a % 6;
			send_cmd(v_b[0], (v_a >= 4) ? v_a[7:0] + 8'd1 : v_a[7:0], v_c);
		end
		wait_drain();
		check_outputs();
		read_all();
		if (u_dut.u_core.u_asserts.err_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			abort_run("Concurrent assertion failed during the run");
		end
	end

endmodule

`default_nettype wire

// ==== tb/io_asserts.sv ====
// Module io_asserts, concurrent checks on the io_core response strobe and data rules
`timescale 1ns/1ps
`default_nettype none

module io_asserts (
	input logic             clock_i,
	input logic             rst_n_i,
	input logic             cmd_valid_i,
	input logic             rsp_valid_i,
	input io_pkg::io_data_t rsp_rdata_i,
	input logic             rsp_err_i
);

	int err_count = 0;	// Read by the testbench at the end of the run

	// Synchronous reset clears the strobe one edge later
	reset_quiet: assert property (@(posedge clock_i) !rst_n_i |=> !rsp_valid_i)
		else begin
			$error("Response strobe high during reset");
			err_count++;
		end

	// Three pipeline stages between command and response
	rsp_after_cmd: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		cmd_valid_i |-> ##3 rsp_valid_i)
		else begin
			$error("Command not answered three cycles later");
			err_count++;
		end

	rsp_has_cmd: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		rsp_valid_i |-> $past(cmd_valid_i, 3))
		else begin
			$error("Response strobe without a command three cycles earlier");
			err_count++;
		end

	err_zero_data: assert property (@(posedge clock_i) disable iff (!rst_n_i)
		(rsp_valid_i && rsp_err_i) |-> (rsp_rdata_i == '0))
		else begin
			$error("Error response carries nonzero data");
			err_count++;
		end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// Module tb_clock_gen, free-running testbench clock and synchronous reset pulse
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS    = 8.0,
	parameter int  RESET_CYCLES = 16
) (
	output logic clock_o,
	output logic rst_n_o
);

	initial begin
		clock_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clock_o = ~clock_o;
	end

	initial begin
		rst_n_o = 1'b0;	// Held low from time zero
		repeat (RESET_CYCLES) @(posedge clock_o);
		rst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== hw/io_pad_top.sv ====
// Module io_pad_top, PS/2 and SD tristate pads around the I/O core
`timescale 1ns/1ps
`default_nettype none

`include "io_cfg.svh"

module io_pad_top (
	input  logic                  clock_i,
	input  logic                  rst_n_i,
	input  logic                  cmd_valid_i,
	input  logic                  cmd_write_i,
	input  logic [`IO_ADDR_W-1:0] cmd_addr_i,
	input  io_pkg::io_data_t      cmd_wdata_i,
	output logic                  rsp_valid_o,
	output io_pkg::io_data_t      rsp_rdata_o,
	output logic                  rsp_err_o,
	output logic [7:0]            seg_char_o,
	output logic [7:0]            seg_seg_o,
	inout  wire                   ps2_clk,
	inout  wire                   ps2_data,
	inout  wire  [`IO_SDC_W-1:0]  sdc_dat
);

	logic [`IO_PS2_W-1:0] ps2_in;
	logic [`IO_PS2_W-1:0] ps2_out;
	logic [`IO_PS2_W-1:0] ps2_drv;
	logic [`IO_SDC_W-1:0] sdc_in;
	logic [`IO_SDC_W-1:0] sdc_out;
	logic [`IO_SDC_W-1:0] sdc_drv;

	// Released lines float up to the board pull-ups
	assign ps2_clk  = ps2_drv[0] ? ps2_out[0] : 1'bz;
	assign ps2_data = ps2_drv[1] ? ps2_out[1] : 1'bz;
	assign ps2_in   = {ps2_data, ps2_clk};

	for (genvar i = 0; i < `IO_SDC_W; i++) begin : g_sdc_pad
		assign sdc_dat[i] = sdc_drv[i] ? sdc_out[i] : 1'bz;
	end

	// Raw pad levels, synchronized inside the core
	assign sdc_in = sdc_dat;

	io_core u_core (
		.clock_i     (clock_i),
		.rst_n_i     (rst_n_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_write_i (cmd_write_i),
		.cmd_addr_i  (cmd_addr_i),
		.cmd_wdata_i (cmd_wdata_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_rdata_o (rsp_rdata_o),
		.rsp_err_o   (rsp_err_o),
		.seg_char_o  (seg_char_o),
		.seg_seg_o   (seg_seg_o),
		.ps2_in_i    (ps2_in),
		.ps2_out_o   (ps2_out),
		.ps2_drv_o   (ps2_drv),
		.sdc_in_i    (sdc_in),
		.sdc_out_o   (sdc_out),
		.sdc_drv_o   (sdc_drv)
	);

endmodule

`default_nettype wire

// ==== hw/io_core.sv ====
// Module io_core, decode, execute and result stages of the host command path
`timescale 1ns/1ps
`default_nettype none

`include "io_cfg.svh"

module io_core (
	input  logic                  clock_i,
	input  logic                  rst_n_i,
	input  logic                  cmd_valid_i,
	input  logic                  cmd_write_i,
	input  logic [`IO_ADDR_W-1:0] cmd_addr_i,
	input  io_pkg::io_data_t      cmd_wdata_i,
	output logic                  rsp_valid_o,
	output io_pkg::io_data_t      rsp_rdata_o,
	output logic                  rsp_err_o,
	output logic [7:0]            seg_char_o,
	output logic [7:0]            seg_seg_o,
	input  logic [`IO_PS2_W-1:0]  ps2_in_i,
	output logic [`IO_PS2_W-1:0]  ps2_out_o,
	output logic [`IO_PS2_W-1:0]  ps2_drv_o,
	input  logic [`IO_SDC_W-1:0]  sdc_in_i,
	output logic [`IO_SDC_W-1:0]  sdc_out_o,
	output logic [`IO_SDC_W-1:0]  sdc_drv_o
);
	import io_pkg::*;

	logic     dec_valid;
	logic     dec_write;
	io_reg_e  dec_reg;
	io_data_t dec_wdata;
	logic     dec_err;
	logic     exe_valid;
	logic     exe_err;
	io_data_t exe_rdata;

	io_decode u_decode (	// Edge 1
		.clock_i     (clock_i),
		.rst_n_i     (rst_n_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_write_i (cmd_write_i),
		.cmd_addr_i  (cmd_addr_i),
		.cmd_wdata_i (cmd_wdata_i),
		.dec_valid_o (dec_valid),
		.dec_write_o (dec_write),
		.dec_reg_o   (dec_reg),
		.dec_wdata_o (dec_wdata),
		.dec_err_o   (dec_err)
	);

	io_execute u_execute (	// Edge 2
		.clock_i     (clock_i),
		.rst_n_i     (rst_n_i),
		.dec_valid_i (dec_valid),
		.dec_write_i (dec_write),
		.dec_reg_i   (dec_reg),
		.dec_wdata_i (dec_wdata),
		.dec_err_i   (dec_err),
		.ps2_in_i    (ps2_in_i),
		.sdc_in_i    (sdc_in_i),
		.exe_valid_o (exe_valid),
		.exe_err_o   (exe_err),
		.exe_rdata_o (exe_rdata),
		.seg_char_o  (seg_char_o),
		.seg_seg_o   (seg_seg_o),
		.ps2_out_o   (ps2_out_o),
		.ps2_drv_o   (ps2_drv_o),
		.sdc_out_o   (sdc_out_o),
		.sdc_drv_o   (sdc_drv_o)
	);

	io_result u_result (	// Edge 3
		.clock_i     (clock_i),
		.rst_n_i     (rst_n_i),
		.exe_valid_i (exe_valid),
		.exe_err_i   (exe_err),
		.exe_rdata_i (exe_rdata),
		.rsp_valid_o (rsp_valid_o),
		.rsp_rdata_o (rsp_rdata_o),
		.rsp_err_o   (rsp_err_o)
	);

endmodule

`default_nettype wire

// ==== hw/io_result.sv ====
// Module io_result, response register for strobe, read data and error flag
`timescale 1ns/1ps
`default_nettype none

module io_result (
	input  logic             clock_i,
	input  logic             rst_n_i,
	input  logic             exe_valid_i,
	input  logic             exe_err_i,
	input  io_pkg::io_data_t exe_rdata_i,
	output logic             rsp_valid_o,
	output io_pkg::io_data_t rsp_rdata_o,
	output logic             rsp_err_o
);

	// Strobe is high for exactly one cycle per command
	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			rsp_valid_o <= 1'b0;
			rsp_err_o   <= 1'b0;
		end else begin
			rsp_valid_o <= exe_valid_i;
			if (exe_valid_i) begin
				rsp_err_o <= exe_err_i;
			end
		end
	end

	// Data keeps the last response until the next one
	always_ff @(posedge clock_i) begin
		if (exe_valid_i) begin
			rsp_rdata_o <= exe_rdata_i;
		end
	end

endmodule

`default_nettype wire

// ==== hw/io_execute.sv ====
// Module io_execute, register file, pin input sampling and read data capture
`timescale 1ns/1ps
`default_nettype none

`include "io_cfg.svh"

module io_execute (
	input  logic                  clock_i,
	input  logic                  rst_n_i,
	input  logic                  dec_valid_i,
	input  logic                  dec_write_i,
	input  io_pkg::io_reg_e       dec_reg_i,
	input  io_pkg::io_data_t      dec_wdata_i,
	input  logic                  dec_err_i,
	input  logic [`IO_PS2_W-1:0]  ps2_in_i,
	input  logic [`IO_SDC_W-1:0]  sdc_in_i,
	output logic                  exe_valid_o,
	output logic                  exe_err_o,
	output io_pkg::io_data_t      exe_rdata_o,
	output logic [7:0]            seg_char_o,
	output logic [7:0]            seg_seg_o,
	output logic [`IO_PS2_W-1:0]  ps2_out_o,
	output logic [`IO_PS2_W-1:0]  ps2_drv_o,
	output logic [`IO_SDC_W-1:0]  sdc_out_o,
	output logic [`IO_SDC_W-1:0]  sdc_drv_o
);
	import io_pkg::*;

	logic [7:0]           seg_char_q;
	logic [7:0]           seg_seg_q;
	logic [`IO_PS2_W-1:0] ps2_out_q;
	logic [`IO_PS2_W-1:0] ps2_drv_q;
	logic [`IO_SDC_W-1:0] sdc_out_q;
	logic [`IO_SDC_W-1:0] sdc_drv_q;
	logic [`IO_PS2_W-1:0] ps2_sync;
	logic [`IO_SDC_W-1:0] sdc_sync;
	logic                 wr_en;
	logic                 rd_en;
	io_data_t             rd_data;

	io_pin_sync #(
		.payload_t(logic [`IO_PS2_W-1:0])
	) u_ps2_sync (
		.clock_i (clock_i),
		.rst_n_i (rst_n_i),
		.async_i (ps2_in_i),
		.sync_o  (ps2_sync)
	);

	io_pin_sync #(
		.payload_t(logic [`IO_SDC_W-1:0])
	) u_sdc_sync (
		.clock_i (clock_i),
		.rst_n_i (rst_n_i),
		.async_i (sdc_in_i),
		.sync_o  (sdc_sync)
	);

	// Errored commands have no effect
	assign wr_en = dec_valid_i && dec_write_i && !dec_err_i;
	assign rd_en = dec_valid_i && !dec_write_i && !dec_err_i;

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			seg_char_q <= '0;
			seg_seg_q  <= '0;
			ps2_out_q  <= '0;
			ps2_drv_q  <= '0;	// All pads released
			sdc_out_q  <= '0;
			sdc_drv_q  <= '0;
		end else if (wr_en) begin
			case (dec_reg_i)
				REG_SEG_CHAR: seg_char_q <= dec_wdata_i[7:0];
				REG_SEG_SEG:  seg_seg_q  <= dec_wdata_i[7:0];
				REG_PS2_OUT:  ps2_out_q  <= dec_wdata_i[`IO_PS2_W-1:0];
				REG_PS2_DRV:  ps2_drv_q  <= dec_wdata_i[`IO_PS2_W-1:0];
				REG_SDC_OUT:  sdc_out_q  <= dec_wdata_i[`IO_SDC_W-1:0];
				REG_SDC_DRV:  sdc_drv_q  <= dec_wdata_i[`IO_SDC_W-1:0];
				default: ;	// Read-only, already flagged by decode
			endcase
		end
	end

	// Zero-extended read view of the selected register
	always_comb begin
		rd_data = '0;
		case (dec_reg_i)
			REG_SEG_CHAR: rd_data[7:0]           = seg_char_q;
			REG_SEG_SEG:  rd_data[7:0]           = seg_seg_q;
			REG_PS2_OUT:  rd_data[`IO_PS2_W-1:0] = ps2_out_q;
			REG_PS2_DRV:  rd_data[`IO_PS2_W-1:0] = ps2_drv_q;
			REG_PS2_IN:   rd_data[`IO_PS2_W-1:0] = ps2_sync;
			REG_SDC_OUT:  rd_data[`IO_SDC_W-1:0] = sdc_out_q;
			REG_SDC_DRV:  rd_data[`IO_SDC_W-1:0] = sdc_drv_q;
			REG_SDC_IN:   rd_data[`IO_SDC_W-1:0] = sdc_sync;
			default:      rd_data                = '0;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			exe_valid_o <= 1'b0;
			exe_err_o   <= 1'b0;
		end else begin
			exe_valid_o <= dec_valid_i;
			exe_err_o   <= dec_valid_i && dec_err_i;
		end
	end

	// Writes and errors return zero data
	always_ff @(posedge clock_i) begin
		exe_rdata_o <= rd_en ? rd_data : '0;
	end

	assign seg_char_o = seg_char_q;
	assign seg_seg_o  = seg_seg_q;
	assign ps2_out_o  = ps2_out_q;
	assign ps2_drv_o  = ps2_drv_q;
	assign sdc_out_o  = sdc_out_q;
	assign sdc_drv_o  = sdc_drv_q;

endmodule

`default_nettype wire

// ==== hw/io_decode.sv ====
// Module io_decode, command register with address decode and legality check
`timescale 1ns/1ps
`default_nettype none

`include "io_cfg.svh"

module io_decode (
	input  logic                  clock_i,
	input  logic                  rst_n_i,
	input  logic                  cmd_valid_i,
	input  logic                  cmd_write_i,
	input  logic [`IO_ADDR_W-1:0] cmd_addr_i,
	input  io_pkg::io_data_t      cmd_wdata_i,
	output logic                  dec_valid_o,
	output logic                  dec_write_o,
	output io_pkg::io_reg_e       dec_reg_o,
	output io_pkg::io_data_t      dec_wdata_o,
	output logic                  dec_err_o
);
	import io_pkg::*;

	localparam int IDX_W = $bits(io_reg_e);

	io_reg_e reg_sel;
	logic    addr_bad;
	logic    ro_write;

	// Low address bits select the register directly
	assign reg_sel = io_reg_e'(cmd_addr_i[IDX_W-1:0]);

	// Anything at or above 8 is outside the map
	assign addr_bad = |cmd_addr_i[`IO_ADDR_W-1:IDX_W];

	// Pin input views cannot be written
	assign ro_write = cmd_write_i && (reg_sel == REG_PS2_IN || reg_sel == REG_SDC_IN);

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			dec_valid_o <= 1'b0;
			dec_write_o <= 1'b0;
			dec_err_o   <= 1'b0;
		end else begin
			dec_valid_o <= cmd_valid_i;
			dec_write_o <= cmd_write_i;
			dec_err_o   <= addr_bad || ro_write;
		end
	end

	// Payload, qualified downstream by dec_valid_o
	always_ff @(posedge clock_i) begin
		dec_reg_o   <= reg_sel;
		dec_wdata_o <= cmd_wdata_i;
	end

endmodule

`default_nettype wire

// ==== hw/io_pin_sync.sv ====
// Module io_pin_sync, multi-flop synchronizer for pad inputs
`timescale 1ns/1ps
`default_nettype none

`include "io_cfg.svh"

module io_pin_sync #(
	parameter type payload_t = logic
) (
	input  logic     clock_i,
	input  logic     rst_n_i,
	input  payload_t async_i,
	output payload_t sync_o
);

	payload_t stage_q [`IO_SYNC_STAGES];

	always_ff @(posedge clock_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `IO_SYNC_STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= async_i;	// First flop sees raw pad level
			for (int i = 1; i < `IO_SYNC_STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign sync_o = stage_q[`IO_SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== hw/io_pkg.sv ====
// Package with the data word type and the register index enum
`default_nettype none

`include "io_cfg.svh"

package io_pkg;

	typedef logic [`IO_DATA_W-1:0] io_data_t;

	// Register address equals its index
	typedef enum logic [2:0] {
		REG_SEG_CHAR = 3'd0,	// Digit enables
		REG_SEG_SEG  = 3'd1,	// Segment bits
		REG_PS2_OUT  = 3'd2,
		REG_PS2_DRV  = 3'd3,
		REG_PS2_IN   = 3'd4,	// Read-only
		REG_SDC_OUT  = 3'd5,
		REG_SDC_DRV  = 3'd6,
		REG_SDC_IN   = 3'd7	// Read-only
	} io_reg_e;

endpackage

`default_nettype wire

// ==== hw/io_cfg.svh ====
// Width, pin count and synchronizer depth macros for the I/O subsystem
`ifndef IO_CFG_SVH
`define IO_CFG_SVH

// Host bus
`define IO_ADDR_W 8
`define IO_DATA_W 32

// PS/2 pins, bit 0 clock and bit 1 data
`define IO_PS2_W 2

// SD card data lines
`define IO_SDC_W 4

// Flops in each input synchronizer
`define IO_SYNC_STAGES 2

`endif
